// File: project.f
tlb_geom_pkg.sv
tlb_walk_pkg.sv
tlb_entry.sv
tlb_fill.sv
tlb_select.sv
tlb_top.sv
tlb_assertions.sv
tb_tlb.sv

// File: tb_tlb.sv
`timescale 1ns/10ps

module tb_tlb;

   localparam int N_ENTRIES = 4;
   localparam int PA_W      = 40;
   localparam int CNT_W     = 32;
   localparam int MAX_ROWS  = 64;

   localparam int OP_FILL   = 0;
   localparam int OP_LOOKUP = 1;
   localparam int OP_CLEAR  = 2;
   localparam int OP_BYPASS = 3;

   localparam logic [1:0] SZ_1G  = tlb_walk_pkg::PGSZ_1G;
   localparam logic [1:0] SZ_2M  = tlb_walk_pkg::PGSZ_2M;
   localparam logic [1:0] SZ_4K  = tlb_walk_pkg::PGSZ_4K;
   localparam logic [1:0] SZ_64K = tlb_walk_pkg::PGSZ_64K;

   logic clk = 1'b0;
   logic rst_n;
   logic clear;
   logic active;
   logic req;
   logic replace;
   logic [63:0] va;
   logic [63:0] replace_va;
   logic [51:0] walk_ppn;
   logic [1:0] walk_pgsize;
   logic walk_dirty;
   logic walk_readable;
   logic walk_writable;
   logic walk_executable;
   logic walk_user;
   logic [PA_W-1:0] pa;
   logic hit;
   logic dirty;
   logic readable;
   logic writable;
   logic executable;
   logic user;
   logic zero_page;
   logic [CNT_W-1:0] hit_count;
   logic [CNT_W-1:0] access_count;

   // stimulus table with fill data or expected lookup flags in row_flags
   int row_op [MAX_ROWS];
   int row_test [MAX_ROWS];
   logic [63:0] row_va [MAX_ROWS];
   logic [51:0] row_ppn [MAX_ROWS];
   logic [1:0] row_sz [MAX_ROWS];
   logic [4:0] row_flags [MAX_ROWS];
   logic row_hit [MAX_ROWS];
   logic [PA_W-1:0] row_pa [MAX_ROWS];
   logic row_zero [MAX_ROWS];
   int n_rows = 0;

   // reference copy of the entries and the round robin victim
   logic [63:0] m_va [N_ENTRIES];
   logic [51:0] m_ppn [N_ENTRIES];
   logic [1:0] m_sz [N_ENTRIES];
   logic [4:0] m_flags [N_ENTRIES];
   logic m_valid [N_ENTRIES] = '{default: 1'b0};
   int m_victim = 0;

   int seed = 25;
   int n_checks = 0;
   int n_errors = 0;
   int exp_access = 0;
   int exp_hits = 0;
   int mark_checks = 0;
   int mark_errors = 0;
   int tests_done = 0;
   bit reset_ok;
   string test_name [1:6] = '{"reset values", "bypass", "fill and lookup per page size",
                              "clear and refill", "round robin eviction", "counters"};

   tlb_top #(.N_ENTRIES(N_ENTRIES), .PA_W(PA_W), .CNT_W(CNT_W)) dut_i (.*);

   always #4 clk = ~clk;

   initial
   begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

   task automatic check(input string name, input logic [63:0] expected,
                        input logic [63:0] actual);
      n_checks++;
      if (actual !== expected)
      begin
         n_errors++;
         $display("MISMATCH at %0t: %s expected 0x%0h actual 0x%0h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic report_test(input int id);
      $display("test %0d %s: %0d checks, %0d mismatches", id, test_name[id],
               n_checks - mark_checks, n_errors - mark_errors);
      mark_checks = n_checks;
      mark_errors = n_errors;
      tests_done++;
   endtask

   function automatic int ofs_width(input logic [1:0] sz);
      case (sz)
         SZ_1G:   return tlb_geom_pkg::OFS_1G;
         SZ_2M:   return tlb_geom_pkg::OFS_2M;
         SZ_4K:   return tlb_geom_pkg::OFS_4K;
         default: return tlb_geom_pkg::OFS_64K;
      endcase
   endfunction

   // reference pa with the page number above the offset and va below it
   function automatic logic [PA_W-1:0] compose(input logic [51:0] ppn, input int ofs,
                                               input logic [63:0] addr);
      logic [63:0] full;
      full = (({ppn, 12'h000} >> ofs) << ofs) | (addr & ((64'd1 << ofs) - 64'd1));
      return full[PA_W-1:0];
   endfunction

   function automatic logic [63:0] rand_ofs(input int width);
      logic [63:0] r;
      r = {32'h0, $random(seed)};
      return r & ((64'd1 << width) - 64'd1);
   endfunction

   task automatic start_row(input int test, input int op, input logic [63:0] addr);
      row_op[n_rows] = op;
      row_test[n_rows] = test;
      row_va[n_rows] = addr;
      row_ppn[n_rows] = '0;
      row_sz[n_rows] = '0;
      row_flags[n_rows] = '0;
      row_hit[n_rows] = 1'b0;
      row_pa[n_rows] = '0;
      row_zero[n_rows] = (addr[39:12] == '0);
   endtask

   task automatic add_fill(input int test, input logic [63:0] addr, input logic [51:0] ppn,
                           input logic [1:0] sz, input logic [4:0] flags);
      start_row(test, OP_FILL, addr);
      row_ppn[n_rows] = ppn;
      row_sz[n_rows] = sz;
      row_flags[n_rows] = flags;
      m_va[m_victim] = addr;
      m_ppn[m_victim] = ppn;
      m_sz[m_victim] = sz;
      m_flags[m_victim] = flags;
      m_valid[m_victim] = 1'b1;
      m_victim = (m_victim == N_ENTRIES - 1) ? 0 : m_victim + 1;
      n_rows++;
   endtask

   task automatic add_lookup(input int test, input logic [63:0] addr);
      int ofs;
      start_row(test, OP_LOOKUP, addr);
      for (int e = 0; e < N_ENTRIES; e++)
      begin
         ofs = ofs_width(m_sz[e]);
         if (!row_hit[n_rows] && m_valid[e] && (addr[39:0] >> ofs) == (m_va[e][39:0] >> ofs))
         begin
            row_hit[n_rows] = 1'b1;
            row_pa[n_rows] = compose(m_ppn[e], ofs, addr);
            row_flags[n_rows] = m_flags[e];
         end
      end
      exp_access++;
      exp_hits += row_hit[n_rows];
      n_rows++;
   endtask

   task automatic add_clear(input int test);
      start_row(test, OP_CLEAR, '0);
      m_valid = '{default: 1'b0};
      n_rows++;
   endtask

   task automatic add_bypass(input int test, input logic [63:0] addr);
      start_row(test, OP_BYPASS, addr);
      row_hit[n_rows] = 1'b1;
      row_pa[n_rows] = addr[PA_W-1:0];
      n_rows++;
   endtask

   task automatic build_table();
      add_bypass(2, 64'h0000_0012_3456_789A);
      add_bypass(2, 64'hFFFF_FFAB_CDEF_0123);
      add_bypass(2, 64'h0000_0000_0000_0FFF);
      add_fill(3, 64'h00_4000_0000, 52'h2AC_1234, SZ_1G, 5'b11101);
      add_fill(3, 64'h12_3460_0000, 52'h5_5A0F, SZ_2M, 5'b01010);
      add_fill(3, 64'h00_0000_0000, 52'h7_7777, SZ_4K, 5'b10011);
      add_fill(3, 64'h7F_FFF1_0000, 52'hA_BCDE, SZ_64K, 5'b01100);
      add_lookup(3, 64'h00_4000_0000 | rand_ofs(30));
      add_lookup(3, 64'h00_7FFF_FFFF);
      add_lookup(3, 64'h12_3460_0000 | rand_ofs(21));
      add_lookup(3, 64'h00_0000_0ABC);
      add_lookup(3, 64'h7F_FFF1_0000 | rand_ofs(16));
      add_lookup(3, 64'h80_0000_0000);
      add_lookup(3, 64'h12_3480_0000);
      add_lookup(3, 64'h00_0000_1000);
      add_lookup(3, 64'h7F_FFF2_0000);
      add_clear(4);
      add_lookup(4, 64'h00_4000_0000 | rand_ofs(30));
      add_lookup(4, 64'h12_3460_0000);
      add_lookup(4, 64'h00_0000_0123);
      add_lookup(4, 64'h7F_FFF1_8000);
      add_fill(4, 64'h00_4000_0000, 52'h2AC_1234, SZ_1G, 5'b11101);
      add_fill(4, 64'h00_0000_0000, 52'h7_7777, SZ_4K, 5'b10011);
      add_lookup(4, 64'h00_4000_0000 | rand_ofs(30));
      add_lookup(4, 64'h00_0000_0000 | rand_ofs(12));
      add_lookup(4, 64'h12_3460_0000);
      add_clear(5);
      for (int k = 1; k <= 5; k++)
      begin
         add_fill(5, 64'h11_1111_1000 * k, 52'h1_1111 * k, SZ_4K, 5'(k * 3));
         if (k == 4)
         begin
            for (int j = 1; j <= 4; j++)
               add_lookup(5, (64'h11_1111_1000 * j) | rand_ofs(12));
         end
      end
      // the first of the five fills is the victim of the fifth
      for (int j = 1; j <= 5; j++)
         add_lookup(5, (64'h11_1111_1000 * j) | rand_ofs(12));
   endtask

   task automatic drive_row(input int i);
      replace = (row_op[i] == OP_FILL);
      clear = (row_op[i] == OP_CLEAR);
      req = (row_op[i] == OP_LOOKUP) || (row_op[i] == OP_BYPASS);
      active = (row_op[i] != OP_BYPASS);
      va = row_va[i];
      replace_va = row_va[i];
      walk_ppn = row_ppn[i];
      walk_pgsize = row_sz[i];
      {walk_dirty, walk_readable, walk_writable, walk_executable, walk_user} = row_flags[i];
   endtask

   task automatic check_row(input int i);
      if (row_op[i] == OP_LOOKUP || row_op[i] == OP_BYPASS)
      begin
         check("hit", row_hit[i], hit);
         check("zero_page", row_zero[i], zero_page);
         if (row_hit[i])
            check("pa", row_pa[i], pa);
         if (row_hit[i] && row_op[i] == OP_LOOKUP)
         begin
            check("dirty", row_flags[i][4], dirty);
            check("readable", row_flags[i][3], readable);
            check("writable", row_flags[i][2], writable);
            check("executable", row_flags[i][1], executable);
            check("user", row_flags[i][0], user);
         end
      end
   endtask

   // rst_n is polled on the rising edge where it is stable
   task automatic wait_reset_release(output bit ok);
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < 50)
      begin
         @(posedge clk);
         cycles++;
      end
      ok = (rst_n === 1'b1);
   endtask

   initial
   begin
      {clear, req, replace, va, replace_va, walk_ppn, walk_pgsize} = '0;
      {walk_dirty, walk_readable, walk_writable, walk_executable, walk_user} = '0;
      active = 1'b1;
      build_table();
      // outputs hold their reset values while rst_n is low
      @(negedge clk);
      check("hit", 0, hit);
      check("zero_page", 0, zero_page);
      check("hit_count", 0, hit_count);
      check("access_count", 0, access_count);
      report_test(1);
      wait_reset_release(reset_ok);
      if (!reset_ok)
      begin
         $display("reset was never released within 50 cycles");
         n_errors++;
      end
      else
      begin
         @(negedge clk);
         for (int i = 0; i < n_rows; i++)
         begin
            drive_row(i);
            @(negedge clk);
            check_row(i);
            if (i == n_rows - 1 || row_test[i + 1] != row_test[i])
               report_test(row_test[i]);
         end
         check("access_count", exp_access, access_count);
         check("hit_count", exp_hits, hit_count);
         report_test(6);
      end
      $display("%0d tests, %0d checks, %0d errors", tests_done, n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("SIMULATION PASSED");
      end
      else
      begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: tlb_assertions.sv
`timescale 1ns/10ps

module tlb_assertions
#(
   parameter int N_ENTRIES = 4
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  clear,
   input  logic                  active,
   input  logic                  req,
   input  logic [N_ENTRIES-1:0]  wr_en,
   input  logic                  hit,
   input  logic                  zero_page
);

   // outputs still carry reset values on the first edge after release
   reset_outputs_low: assert property (@(posedge clk) $rose(rst_n) |-> !hit && !zero_page)
      else $error("hit or zero_page high in the cycle after reset");

   single_victim: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wr_en))
      else $error("more than one entry written in one cycle");

   // no entry is valid in the cycle after clear
   no_hit_after_clear: assert property (@(posedge clk) disable iff (!rst_n)
      clear ##1 (active && req) |=> !hit)
      else $error("hit reported for a lookup in the cycle after clear");

endmodule

bind tlb_top tlb_assertions #(.N_ENTRIES(N_ENTRIES)) assertions_i
(
   .clk       (clk),
   .rst_n     (rst_n),
   .clear     (clear),
   .active    (active),
   .req       (req),
   .wr_en     (wr_en),
   .hit       (hit),
   .zero_page (zero_page)
);

// File: tlb_entry.sv
`timescale 1ns/10ps

module tlb_entry
(
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                inval,
   input  logic                                wr_en,
   input  logic [tlb_geom_pkg::VA_TAG_W-1:0]   wr_tag,
   input  logic [tlb_geom_pkg::PPN_W-1:0]      wr_ppn,
   input  logic [tlb_walk_pkg::PGSZ_W-1:0]     wr_pgsize,
   input  logic                                wr_dirty,
   input  logic                                wr_readable,
   input  logic                                wr_writable,
   input  logic                                wr_executable,
   input  logic                                wr_user,
   input  logic [tlb_geom_pkg::VA_TAG_W-1:0]   lookup_tag,
   output logic                                match,
   output logic [tlb_geom_pkg::PPN_W-1:0]      ppn,
   output logic [tlb_walk_pkg::PGSZ_W-1:0]     pgsize,
   output logic                                dirty,
   output logic                                readable,
   output logic                                writable,
   output logic                                executable,
   output logic                                user
);

   logic                                valid;
   logic [tlb_geom_pkg::VA_TAG_W-1:0]   tag;
   logic [tlb_geom_pkg::VA_TAG_W-1:0]   tag_mask;

   // invalidate has priority over a write in the same cycle
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid <= 1'b0;
      end
      else if (inval)
      begin
         valid <= 1'b0;
      end
      else if (wr_en)
      begin
         valid <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         tag        <= wr_tag;
         ppn        <= wr_ppn;
         pgsize     <= wr_pgsize;
         dirty      <= wr_dirty;
         readable   <= wr_readable;
         writable   <= wr_writable;
         executable <= wr_executable;
         user       <= wr_user;
      end
   end

   // tag bits below the page offset boundary are don't care
   always_comb
   begin
      case (pgsize)
         tlb_walk_pkg::PGSZ_1G:
         begin
            tag_mask = {tlb_geom_pkg::VA_TAG_W{1'b1}}
                       << (tlb_geom_pkg::OFS_1G - tlb_geom_pkg::VA_TAG_LSB);
         end
         tlb_walk_pkg::PGSZ_2M:
         begin
            tag_mask = {tlb_geom_pkg::VA_TAG_W{1'b1}}
                       << (tlb_geom_pkg::OFS_2M - tlb_geom_pkg::VA_TAG_LSB);
         end
         tlb_walk_pkg::PGSZ_64K:
         begin
            tag_mask = {tlb_geom_pkg::VA_TAG_W{1'b1}}
                       << (tlb_geom_pkg::OFS_64K - tlb_geom_pkg::VA_TAG_LSB);
         end
         tlb_walk_pkg::PGSZ_4K:
         begin
            tag_mask = {tlb_geom_pkg::VA_TAG_W{1'b1}}
                       << (tlb_geom_pkg::OFS_4K - tlb_geom_pkg::VA_TAG_LSB);
         end
         default:
         begin
            tag_mask = {tlb_geom_pkg::VA_TAG_W{1'b1}};
         end
      endcase
   end

   assign match = valid && (((tag ^ lookup_tag) & tag_mask) == '0);

endmodule

// File: tlb_fill.sv
`timescale 1ns/10ps

module tlb_fill
#(
   parameter int N_ENTRIES = 4
)
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  replace,
   input  logic                  clear,
   output logic [N_ENTRIES-1:0]  wr_en,
   output logic                  inval
);

   localparam int PTR_W = $clog2(N_ENTRIES);
   localparam logic [PTR_W-1:0] LAST = PTR_W'(N_ENTRIES - 1);

   logic [PTR_W-1:0] victim;
   logic [PTR_W-1:0] victim_nxt;

   // round robin, wraps at the last entry rather than at a power of two
   always_comb
   begin
      if (victim == LAST)
      begin
         victim_nxt = '0;
      end
      else
      begin
         victim_nxt = victim + 1'b1;
      end
   end

   // pointer moves on every fill, even one killed by clear
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         victim <= '0;
      end
      else if (replace)
      begin
         victim <= victim_nxt;
      end
   end

   // one hot write strobe, suppressed when clear arrives together
   always_comb
   begin
      wr_en = '0;
      if (replace && !clear)
      begin
         wr_en[victim] = 1'b1;
      end
   end

   assign inval = clear;

endmodule

// File: tlb_geom_pkg.sv
package tlb_geom_pkg;

   // virtual address window that takes part in translation

   // top translated virtual bit
   localparam int VA_MSB = 39;

   // lowest tag bit, the bottom of a 4K page number
   localparam int VA_TAG_LSB = 12;

   // tag width stored per entry, bits 39 down to 12
   localparam int VA_TAG_W = VA_MSB - VA_TAG_LSB + 1;

   // physical page number as delivered by the walker
   localparam int PPN_W = 52;

   // page offset widths
   // a large page keeps fewer tag bits and takes more offset bits from va

   // 1G pages compare only the top 10 tag bits
   localparam int OFS_1G = 30;

   // 2M pages compare the top 19 tag bits
   localparam int OFS_2M = 21;

   // 4K pages compare the whole tag
   localparam int OFS_4K = 12;

   // 64K pages compare the top 24 tag bits
   localparam int OFS_64K = 16;

endpackage

// File: tlb_select.sv
`timescale 1ns/10ps

module tlb_select
#(
   parameter int N_ENTRIES = 4,
   parameter int PA_W      = 40,
   parameter int CNT_W     = 32
)
(
   input  logic                               clk,
   input  logic                               rst_n,
   input  logic                               active,
   input  logic                               req,
   input  logic [63:0]                        va,
   input  logic [N_ENTRIES-1:0]               match,
   input  logic [tlb_geom_pkg::PPN_W-1:0]     ppn [N_ENTRIES],
   input  logic [tlb_walk_pkg::PGSZ_W-1:0]    pgsize [N_ENTRIES],
   input  logic [N_ENTRIES-1:0]               ent_dirty,
   input  logic [N_ENTRIES-1:0]               ent_readable,
   input  logic [N_ENTRIES-1:0]               ent_writable,
   input  logic [N_ENTRIES-1:0]               ent_executable,
   input  logic [N_ENTRIES-1:0]               ent_user,
   output logic [PA_W-1:0]                    pa,
   output logic                               hit,
   output logic                               dirty,
   output logic                               readable,
   output logic                               writable,
   output logic                               executable,
   output logic                               user,
   output logic                               zero_page,
   output logic [CNT_W-1:0]                   hit_count,
   output logic [CNT_W-1:0]                   access_count
);

   localparam int IDX_W     = $clog2(N_ENTRIES);
   localparam int PA_FULL_W = tlb_geom_pkg::PPN_W + tlb_geom_pkg::VA_TAG_LSB;

   logic [IDX_W-1:0]                       sel_idx;
   logic                                   any_match;
   logic [tlb_geom_pkg::PPN_W-1:0]         sel_ppn;
   logic [tlb_walk_pkg::PGSZ_W-1:0]        sel_pgsize;
   logic [PA_FULL_W-1:0]                   ofs_mask;
   logic [PA_FULL_W-1:0]                   pa_full;

   // priority encoder, the lowest entry wins on multiple matches
   always_comb
   begin
      sel_idx = '0;
      for (int i = N_ENTRIES - 1; i >= 0; i--)
      begin
         if (match[i])
         begin
            sel_idx = IDX_W'(i);
         end
      end
   end

   assign any_match  = |match;
   assign sel_ppn    = ppn[sel_idx];
   assign sel_pgsize = pgsize[sel_idx];

   always_comb
   begin
      case (sel_pgsize)
         tlb_walk_pkg::PGSZ_1G:  ofs_mask = ~({PA_FULL_W{1'b1}} << tlb_geom_pkg::OFS_1G);
         tlb_walk_pkg::PGSZ_2M:  ofs_mask = ~({PA_FULL_W{1'b1}} << tlb_geom_pkg::OFS_2M);
         tlb_walk_pkg::PGSZ_64K: ofs_mask = ~({PA_FULL_W{1'b1}} << tlb_geom_pkg::OFS_64K);
         tlb_walk_pkg::PGSZ_4K:  ofs_mask = ~({PA_FULL_W{1'b1}} << tlb_geom_pkg::OFS_4K);
         default:                ofs_mask = ~({PA_FULL_W{1'b1}} << tlb_geom_pkg::OFS_4K);
      endcase
   end

   // page number above the offset, va below it
   assign pa_full = ({sel_ppn, {tlb_geom_pkg::VA_TAG_LSB{1'b0}}} & ~ofs_mask)
                  | (va[PA_FULL_W-1:0] & ofs_mask);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hit          <= 1'b0;
         zero_page    <= 1'b0;
         hit_count    <= '0;
         access_count <= '0;
      end
      else
      begin
         // bypass reports a hit regardless of req
         hit       <= active ? (req && any_match) : 1'b1;
         zero_page <= (va[tlb_geom_pkg::VA_MSB:tlb_geom_pkg::VA_TAG_LSB] == '0);
         if (active && req)
         begin
            access_count <= access_count + 1'b1;
         end
         if (active && req && any_match)
         begin
            hit_count <= hit_count + 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      pa         <= active ? pa_full[PA_W-1:0] : va[PA_W-1:0];
      dirty      <= ent_dirty[sel_idx];
      readable   <= ent_readable[sel_idx];
      writable   <= ent_writable[sel_idx];
      executable <= ent_executable[sel_idx];
      user       <= ent_user[sel_idx];
   end

endmodule

// File: tlb_top.sv
`timescale 1ns/10ps

module tlb_top
#(
   parameter int N_ENTRIES = 4,
   parameter int PA_W      = 40,
   parameter int CNT_W     = 32
)
(
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             clear,
   input  logic                             active,
   input  logic                             req,
   input  logic [63:0]                      va,
   input  logic                             replace,
   input  logic [63:0]                      replace_va,
   input  logic [tlb_geom_pkg::PPN_W-1:0]   walk_ppn,
   input  logic [tlb_walk_pkg::PGSZ_W-1:0]  walk_pgsize,
   input  logic                             walk_dirty,
   input  logic                             walk_readable,
   input  logic                             walk_writable,
   input  logic                             walk_executable,
   input  logic                             walk_user,
   output logic [PA_W-1:0]                  pa,
   output logic                             hit,
   output logic                             dirty,
   output logic                             readable,
   output logic                             writable,
   output logic                             executable,
   output logic                             user,
   output logic                             zero_page,
   output logic [CNT_W-1:0]                 hit_count,
   output logic [CNT_W-1:0]                 access_count
);

   logic [N_ENTRIES-1:0]                wr_en;
   logic                                inval;
   logic [N_ENTRIES-1:0]                ent_match;
   logic [tlb_geom_pkg::PPN_W-1:0]      ent_ppn [N_ENTRIES];
   logic [tlb_walk_pkg::PGSZ_W-1:0]     ent_pgsize [N_ENTRIES];
   logic [N_ENTRIES-1:0]                ent_dirty;
   logic [N_ENTRIES-1:0]                ent_readable;
   logic [N_ENTRIES-1:0]                ent_writable;
   logic [N_ENTRIES-1:0]                ent_executable;
   logic [N_ENTRIES-1:0]                ent_user;

   tlb_fill #(.N_ENTRIES(N_ENTRIES)) fill_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .replace (replace),
      .clear   (clear),
      .wr_en   (wr_en),
      .inval   (inval)
   );

   // walker response fans out to every entry, wr_en picks the victim
   for (genvar i = 0; i < N_ENTRIES; i++)
   begin : g_entry
      tlb_entry entry_i
      (
         .clk           (clk),
         .rst_n         (rst_n),
         .inval         (inval),
         .wr_en         (wr_en[i]),
         .wr_tag        (replace_va[tlb_geom_pkg::VA_MSB:tlb_geom_pkg::VA_TAG_LSB]),
         .wr_ppn        (walk_ppn),
         .wr_pgsize     (walk_pgsize),
         .wr_dirty      (walk_dirty),
         .wr_readable   (walk_readable),
         .wr_writable   (walk_writable),
         .wr_executable (walk_executable),
         .wr_user       (walk_user),
         .lookup_tag    (va[tlb_geom_pkg::VA_MSB:tlb_geom_pkg::VA_TAG_LSB]),
         .match         (ent_match[i]),
         .ppn           (ent_ppn[i]),
         .pgsize        (ent_pgsize[i]),
         .dirty         (ent_dirty[i]),
         .readable      (ent_readable[i]),
         .writable      (ent_writable[i]),
         .executable    (ent_executable[i]),
         .user          (ent_user[i])
      );
   end

   tlb_select #(.N_ENTRIES(N_ENTRIES), .PA_W(PA_W), .CNT_W(CNT_W)) select_i
   (
      .clk            (clk),
      .rst_n          (rst_n),
      .active         (active),
      .req            (req),
      .va             (va),
      .match          (ent_match),
      .ppn            (ent_ppn),
      .pgsize         (ent_pgsize),
      .ent_dirty      (ent_dirty),
      .ent_readable   (ent_readable),
      .ent_writable   (ent_writable),
      .ent_executable (ent_executable),
      .ent_user       (ent_user),
      .pa             (pa),
      .hit            (hit),
      .dirty          (dirty),
      .readable       (readable),
      .writable       (writable),
      .executable     (executable),
      .user           (user),
      .zero_page      (zero_page),
      .hit_count      (hit_count),
      .access_count   (access_count)
   );

endmodule

// File: tlb_walk_pkg.sv
package tlb_walk_pkg;

   // page size code as returned by the page walker
   localparam int PGSZ_W = 2;

   // size codes
   // same encoding the walker puts into its response

   // gigapage
   localparam logic [PGSZ_W-1:0] PGSZ_1G = 2'd0;

   // megapage
   localparam logic [PGSZ_W-1:0] PGSZ_2M = 2'd1;

   // base page
   localparam logic [PGSZ_W-1:0] PGSZ_4K = 2'd2;

   // 64K contiguous page, 16 base pages mapped as one
   localparam logic [PGSZ_W-1:0] PGSZ_64K = 2'd3;

endpackage
